// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lsu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := CHECKS FAILED
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: axil_dmem.sv
// single outstanding transaction; aw and w are taken only together, words past the depth give SLVERR
`timescale 1ns/10ps
`include "lsu_defs.svh"

module axil_dmem (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_awvalid,
  output logic               o_awready,
  input  lsu_pkg::axil_aw_t  i_aw,
  input  logic               i_wvalid,
  output logic               o_wready,
  input  lsu_pkg::axil_w_t   i_w,
  output logic               o_bvalid,
  input  logic               i_bready,
  output lsu_pkg::axil_b_t   o_b,
  input  logic               i_arvalid,
  output logic               o_arready,
  input  lsu_pkg::axil_ar_t  i_ar,
  output logic               o_rvalid,
  input  logic               i_rready,
  output lsu_pkg::axil_r_t   o_r
);

  localparam int IDX_W = $clog2(`LSU_DMEM_WORDS);
  localparam logic [`LSU_AW-4:0] DEPTH = (`LSU_AW-3)'(`LSU_DMEM_WORDS);

  logic [`LSU_XLEN-1:0] mem [`LSU_DMEM_WORDS];
  logic                 bvalid_q;
  logic                 rvalid_q;
  lsu_pkg::axil_b_t     b_q;
  lsu_pkg::axil_r_t     r_q;
  logic                 pending;
  logic                 wr_fire;
  logic                 rd_fire;
  logic                 wr_in_range;
  logic                 rd_in_range;
  logic [IDX_W-1:0]     wr_idx;
  logic [IDX_W-1:0]     rd_idx;

  assign pending = bvalid_q || rvalid_q;

  // write wins when both address channels arrive together
  assign o_awready = !pending && i_awvalid && i_wvalid;
  assign o_wready  = o_awready;
  assign o_arready = !pending && !(i_awvalid && i_wvalid);

  assign wr_fire = o_awready;  // already needs both valids
  assign rd_fire = i_arvalid && o_arready;

  assign wr_in_range = (i_aw.addr[`LSU_AW-1:3] < DEPTH);
  assign rd_in_range = (i_ar.addr[`LSU_AW-1:3] < DEPTH);
  assign wr_idx      = i_aw.addr[3 +: IDX_W];
  assign rd_idx      = i_ar.addr[3 +: IDX_W];

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (i_bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_fire) begin
      b_q.resp <= wr_in_range ? lsu_pkg::AXIL_OKAY : lsu_pkg::AXIL_SLVERR;
    end
    if (rd_fire) begin
      r_q.data <= rd_in_range ? mem[rd_idx] : '0;  // whole word, lsu picks the lanes
      r_q.resp <= rd_in_range ? lsu_pkg::AXIL_OKAY : lsu_pkg::AXIL_SLVERR;
    end
  end

  // byte-strobed write, out of range leaves memory alone
  always_ff @(posedge i_clk) begin
    if (wr_fire && wr_in_range) begin
      for (int b = 0; b < `LSU_STRB_W; b++) begin
        if (i_w.strb[b]) begin
          mem[wr_idx][b*8 +: 8] <= i_w.data[b*8 +: 8];
        end
      end
    end
  end

  assign o_bvalid = bvalid_q;
  assign o_rvalid = rvalid_q;
  assign o_b      = b_q;
  assign o_r      = r_q;

  a_one_rsp: assert property (@(posedge i_clk) disable iff (!i_rst)
    !(o_bvalid && o_rvalid));

endmodule

// File: filelist.f
+incdir+.
lsu_pkg.sv
lsu_store_align.sv
lsu_load_extend.sv
lsu_axil_master.sv
axil_dmem.sv
lsu_top.sv
tb_lsu_checker.sv
tb_lsu.sv

// File: lsu_axil_master.sv
// one request in flight; misaligned or none requests never reach the bus, prot is fixed at zero
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_axil_master (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_valid,
  output logic                o_req_ready,
  input  lsu_pkg::lsu_req_t   i_req,
  output logic                o_rsp_valid,
  output lsu_pkg::lsu_rsp_t   o_rsp,
  output logic                o_awvalid,
  input  logic                i_awready,
  output lsu_pkg::axil_aw_t   o_aw,
  output logic                o_wvalid,
  input  logic                i_wready,
  output lsu_pkg::axil_w_t    o_w,
  input  logic                i_bvalid,
  output logic                o_bready,
  input  lsu_pkg::axil_b_t    i_b,
  output logic                o_arvalid,
  input  logic                i_arready,
  output lsu_pkg::axil_ar_t   o_ar,
  input  logic                i_rvalid,
  output logic                o_rready,
  input  lsu_pkg::axil_r_t    i_r
);

  typedef enum logic [2:0] {
    st_idle,
    st_local,  // misaligned or none reply
    st_addr,
    st_wait,
    st_reply
  } state_e;

  state_e                  state_q;
  logic                    aw_valid_q;
  logic                    w_valid_q;
  logic                    ar_valid_q;
  logic                    rsp_valid_q;
  lsu_pkg::axil_aw_t       aw_q;
  lsu_pkg::axil_w_t        w_q;
  lsu_pkg::axil_ar_t       ar_q;
  lsu_pkg::lsu_rsp_t       rsp_q;
  lsu_pkg::mem_op_e        op_q;
  logic [2:0]              addr_lo_q;
  logic                    write_q;
  logic [`LSU_STRB_W-1:0]  st_wstrb;
  logic [`LSU_XLEN-1:0]    st_wdata;
  logic                    st_misaligned;
  logic [`LSU_XLEN-1:0]    ld_rdata;
  logic                    req_fire;
  logic                    local_reply;
  logic                    addr_done;
  logic                    b_fire;
  logic                    r_fire;

  lsu_store_align u_store_align (
    .i_op          (i_req.op),
    .i_addr_lo     (i_req.addr[2:0]),
    .i_wdata       (i_req.wdata),
    .o_wstrb       (st_wstrb),
    .o_wdata_lanes (st_wdata),
    .o_misaligned  (st_misaligned)
  );

  lsu_load_extend u_load_extend (
    .i_op      (op_q),
    .i_addr_lo (addr_lo_q),
    .i_rword   (i_r.data),
    .o_rdata   (ld_rdata)
  );

  assign o_req_ready = (state_q == st_idle);
  assign req_fire    = i_req_valid && o_req_ready;
  assign local_reply = (i_req.op == lsu_pkg::op_none) || st_misaligned;

  // every address channel either idle or finishing its handshake this cycle
  assign addr_done = !(aw_valid_q && !i_awready) && !(w_valid_q && !i_wready) &&
                     !(ar_valid_q && !i_arready);

  assign o_bready = (state_q == st_wait) && write_q;
  assign o_rready = (state_q == st_wait) && !write_q;
  assign b_fire   = i_bvalid && o_bready;
  assign r_fire   = i_rvalid && o_rready;

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      state_q     <= st_idle;
      aw_valid_q  <= 1'b0;
      w_valid_q   <= 1'b0;
      ar_valid_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;  // response is a one-cycle pulse
      case (state_q)
        st_idle: begin
          if (req_fire && local_reply) begin
            state_q     <= st_local;
            rsp_valid_q <= 1'b1;
          end else if (req_fire) begin
            state_q    <= st_addr;
            aw_valid_q <= i_req.write;  // aw and w rise together
            w_valid_q  <= i_req.write;
            ar_valid_q <= !i_req.write;
          end
        end
        st_addr: begin
          if (i_awready) aw_valid_q <= 1'b0;
          if (i_wready) w_valid_q <= 1'b0;
          if (i_arready) ar_valid_q <= 1'b0;
          if (addr_done) state_q <= st_wait;
        end
        st_wait: begin
          if (b_fire || r_fire) begin
            state_q     <= st_reply;
            rsp_valid_q <= 1'b1;
          end
        end
        default: begin
          state_q <= st_idle;  // st_local and st_reply last one cycle
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      op_q      <= i_req.op;
      addr_lo_q <= i_req.addr[2:0];
      write_q   <= i_req.write;
      aw_q.addr <= i_req.addr;
      aw_q.prot <= 3'b000;
      ar_q.addr <= i_req.addr;
      ar_q.prot <= 3'b000;
      w_q.data  <= st_wdata;
      w_q.strb  <= st_wstrb;
      rsp_q.data <= '0;
      rsp_q.err  <= st_misaligned;  // none replies clean
    end
    if (b_fire) begin
      rsp_q.data <= '0;
      rsp_q.err  <= (i_b.resp != lsu_pkg::AXIL_OKAY);
    end
    if (r_fire) begin
      rsp_q.data <= (i_r.resp != lsu_pkg::AXIL_OKAY) ? '0 : ld_rdata;
      rsp_q.err  <= (i_r.resp != lsu_pkg::AXIL_OKAY);
    end
  end

  assign o_awvalid   = aw_valid_q;
  assign o_wvalid    = w_valid_q;
  assign o_arvalid   = ar_valid_q;
  assign o_aw        = aw_q;
  assign o_w         = w_q;
  assign o_ar        = ar_q;
  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp       = rsp_q;

  // valid and payload hold while the slave stalls
  a_aw_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_awvalid && !i_awready |=> o_awvalid && $stable(o_aw));
  a_w_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_wvalid && !i_wready |=> o_wvalid && $stable(o_w));
  a_ar_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar));

  a_rsp_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_rsp_valid |=> !o_rsp_valid);

endmodule

// File: lsu_defs.svh
// widths assume a 64-bit core; depth must be a power of two for the word index slice
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data path width in bits
`define LSU_XLEN 64

// core and bus address width
`define LSU_AW 64

// byte lanes per data word
`define LSU_STRB_W (`LSU_XLEN / 8)

// data memory depth in 64-bit words
`define LSU_DMEM_WORDS 512

`endif

// File: lsu_load_extend.sv
// combinational; assumes the access is aligned, op none returns zero
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_load_extend (
  input  lsu_pkg::mem_op_e      i_op,
  input  logic [2:0]            i_addr_lo,
  input  logic [`LSU_XLEN-1:0]  i_rword,
  output logic [`LSU_XLEN-1:0]  o_rdata
);

  logic [`LSU_XLEN-1:0] lanes_low;  // addressed lanes moved to bit 0

  assign lanes_low = i_rword >> {i_addr_lo, 3'b000};

  always_comb begin
    case (i_op)
      lsu_pkg::op_lb: begin
        o_rdata = {{(`LSU_XLEN-8){lanes_low[7]}}, lanes_low[7:0]};
      end
      lsu_pkg::op_lbu: begin
        o_rdata = {{(`LSU_XLEN-8){1'b0}}, lanes_low[7:0]};
      end
      lsu_pkg::op_lh: begin
        o_rdata = {{(`LSU_XLEN-16){lanes_low[15]}}, lanes_low[15:0]};
      end
      lsu_pkg::op_lhu: begin
        o_rdata = {{(`LSU_XLEN-16){1'b0}}, lanes_low[15:0]};
      end
      lsu_pkg::op_lw: begin
        o_rdata = {{(`LSU_XLEN-32){lanes_low[31]}}, lanes_low[31:0]};
      end
      lsu_pkg::op_lwu: begin
        o_rdata = {{(`LSU_XLEN-32){1'b0}}, lanes_low[31:0]};
      end
      lsu_pkg::op_ld: begin
        o_rdata = lanes_low;  // offset is zero when aligned
      end
      default: begin
        o_rdata = '0;
      end
    endcase
  end

endmodule

// File: lsu_pkg.sv
// shared types for the load/store unit; AXI4-Lite only, no bursts, ids or user signals
`include "lsu_defs.svh"

package lsu_pkg;

  // memory operation codes, size in bits [2:1], unsigned flag in bit 0
  typedef enum logic [2:0] {
    op_lb   = 3'd0,
    op_lbu  = 3'd1,
    op_lh   = 3'd2,
    op_lhu  = 3'd3,
    op_lw   = 3'd4,
    op_lwu  = 3'd5,
    op_ld   = 3'd6,
    op_none = 3'd7
  } mem_op_e;

  typedef struct packed {
    logic [`LSU_AW-1:0]   addr;
    logic [`LSU_XLEN-1:0] wdata;
    mem_op_e              op;
    logic                 write;  // 1 = store
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] data;  // extended load data, zero on stores
    logic                 err;
  } lsu_rsp_t;

  typedef struct packed {
    logic [`LSU_AW-1:0] addr;
    logic [2:0]         prot;
  } axil_aw_t;

  typedef struct packed {
    logic [`LSU_AW-1:0] addr;
    logic [2:0]         prot;
  } axil_ar_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] data;
    logic [1:0]           resp;
  } axil_r_t;

  localparam logic [1:0] AXIL_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_SLVERR = 2'b10;

endpackage

// File: lsu_store_align.sv
// combinational; op none yields an empty strobe, misaligned strobes are not meaningful
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_store_align (
  input  lsu_pkg::mem_op_e        i_op,
  input  logic [2:0]              i_addr_lo,
  input  logic [`LSU_XLEN-1:0]    i_wdata,
  output logic [`LSU_STRB_W-1:0]  o_wstrb,
  output logic [`LSU_XLEN-1:0]    o_wdata_lanes,
  output logic                    o_misaligned
);

  logic [`LSU_STRB_W-1:0] size_mask;  // strobe pattern before the lane shift
  logic [5:0]             lane_shamt;  // byte offset in bits

  assign lane_shamt = {i_addr_lo, 3'b000};

  always_comb begin
    size_mask    = '0;
    o_misaligned = 1'b0;
    case (i_op)
      lsu_pkg::op_lb, lsu_pkg::op_lbu: begin
        size_mask = 8'h01;  // any byte offset is fine
      end
      lsu_pkg::op_lh, lsu_pkg::op_lhu: begin
        size_mask    = 8'h03;
        o_misaligned = i_addr_lo[0];
      end
      lsu_pkg::op_lw, lsu_pkg::op_lwu: begin
        size_mask    = 8'h0f;
        o_misaligned = |i_addr_lo[1:0];
      end
      lsu_pkg::op_ld: begin
        size_mask    = 8'hff;
        o_misaligned = |i_addr_lo;
      end
      default: begin
        size_mask    = '0;  // none touches no lane
        o_misaligned = 1'b0;
      end
    endcase
  end

  assign o_wstrb       = size_mask << i_addr_lo;
  assign o_wdata_lanes = i_wdata << lane_shamt;  // upper bytes fall outside the strobe

endmodule

// File: lsu_top.sv
// load/store unit with its private data memory; core must accept every response pulse
`timescale 1ns/10ps

module lsu_top (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_req_valid,
  output logic               o_req_ready,
  input  lsu_pkg::lsu_req_t  i_req,
  output logic               o_rsp_valid,
  output lsu_pkg::lsu_rsp_t  o_rsp
);

  logic              awvalid;
  logic              awready;
  lsu_pkg::axil_aw_t aw;
  logic              wvalid;
  logic              wready;
  lsu_pkg::axil_w_t  w;
  logic              bvalid;
  logic              bready;
  lsu_pkg::axil_b_t  b;
  logic              arvalid;
  logic              arready;
  lsu_pkg::axil_ar_t ar;
  logic              rvalid;
  logic              rready;
  lsu_pkg::axil_r_t  r;

  lsu_axil_master u_master (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .o_awvalid   (awvalid),
    .i_awready   (awready),
    .o_aw        (aw),
    .o_wvalid    (wvalid),
    .i_wready    (wready),
    .o_w         (w),
    .i_bvalid    (bvalid),
    .o_bready    (bready),
    .i_b         (b),
    .o_arvalid   (arvalid),
    .i_arready   (arready),
    .o_ar        (ar),
    .i_rvalid    (rvalid),
    .o_rready    (rready),
    .i_r         (r)
  );

  axil_dmem u_dmem (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_aw      (aw),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_w       (w),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_b       (b),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_ar      (ar),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_r       (r)
  );

endmodule

// File: tb_lsu.sv
// drives lsu_top from a stimulus table; dmem words are never reset, so loads only target written words
`timescale 1ns/10ps
`include "lsu_defs.svh"

module tb_lsu;

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 5;
  localparam int CYCLES_PER_ENTRY = 20;  // response budget for one table entry
  localparam int RANDOM_PAIRS     = 20;

  typedef struct packed {
    logic [95:0]          name;  // up to 12 characters
    lsu_pkg::mem_op_e     op;
    logic                 write;
    logic [`LSU_AW-1:0]   addr;
    logic [`LSU_XLEN-1:0] data;
    logic [`LSU_XLEN-1:0] exp_data;
    logic                 exp_err;
  } entry_t;

  logic              clk;
  logic              rst;
  logic              req_valid;
  logic              req_ready;
  lsu_pkg::lsu_req_t req;
  logic              rsp_valid;
  lsu_pkg::lsu_rsp_t rsp;
  lsu_pkg::lsu_rsp_t exp_rsp;
  logic [95:0]       cur_name;
  int                cur_index;
  int                errors;
  int                checks;
  integer            seed;
  bit                table_built;
  entry_t            table_q[$];

  lsu_top u_dut (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .i_req       (req),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp)
  );

  tb_lsu_checker u_chk (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_req_valid (req_valid),
    .i_req_ready (req_ready),
    .i_req       (req),
    .i_rsp_valid (rsp_valid),
    .i_rsp       (rsp),
    .i_exp       (exp_rsp),
    .i_name      (cur_name),
    .i_index     (cur_index),
    .o_errors    (errors),
    .o_checks    (checks)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // sign or zero extension of the low lanes by load type
  function automatic logic [`LSU_XLEN-1:0] extend_value(input lsu_pkg::mem_op_e op,
                                                        input logic [`LSU_XLEN-1:0] v);
    case (op)
      lsu_pkg::op_lb:  return {{56{v[7]}}, v[7:0]};
      lsu_pkg::op_lbu: return {56'd0, v[7:0]};
      lsu_pkg::op_lh:  return {{48{v[15]}}, v[15:0]};
      lsu_pkg::op_lhu: return {48'd0, v[15:0]};
      lsu_pkg::op_lw:  return {{32{v[31]}}, v[31:0]};
      lsu_pkg::op_lwu: return {32'd0, v[31:0]};
      lsu_pkg::op_ld:  return v;
      default:         return '0;
    endcase
  endfunction

  task automatic add_entry(input logic [95:0] name, input lsu_pkg::mem_op_e op,
                           input logic write, input logic [63:0] addr, input logic [63:0] data,
                           input logic [63:0] exp_data, input logic exp_err);
    entry_t e;
    e.name     = name;
    e.op       = op;
    e.write    = write;
    e.addr     = addr;
    e.data     = data;
    e.exp_data = exp_data;
    e.exp_err  = exp_err;
    table_q.push_back(e);
  endtask

  // store then load the same size at the same aligned spot, words 64 to 127
  task automatic add_random_pairs(input int count);
    logic [31:0]          rnd;
    logic [2:0]           op_bits;
    logic [2:0]           off;
    logic [`LSU_AW-1:0]   addr;
    logic [`LSU_XLEN-1:0] data;
    lsu_pkg::mem_op_e     op;
    for (int i = 0; i < count; i++) begin
      rnd     = $unsigned($random(seed));
      op_bits = 3'(rnd % 32'd7);
      op      = lsu_pkg::mem_op_e'(op_bits);
      off     = rnd[10:8] & ~((3'd1 << op_bits[2:1]) - 3'd1);  // clear bits below the size
      addr    = {54'd0, 1'b1, rnd[21:16], off};
      data    = {$random(seed), $random(seed)};
      add_entry("rand_store", op, 1'b1, addr, data, 64'h0, 1'b0);
      add_entry("rand_load", op, 1'b0, addr, 64'h0, extend_value(op, data), 1'b0);
    end
  endtask

  task automatic build_table();
    add_entry("st_full", lsu_pkg::op_ld, 1'b1, 64'h100, 64'hf0e1_d2c3_b4a5_9687, 64'h0, 1'b0);
    add_entry("lb_b0", lsu_pkg::op_lb, 1'b0, 64'h100, 64'h0, 64'hffff_ffff_ffff_ff87, 1'b0);
    add_entry("lbu_b3", lsu_pkg::op_lbu, 1'b0, 64'h103, 64'h0, 64'h0000_0000_0000_00b4, 1'b0);
    add_entry("lb_b5", lsu_pkg::op_lb, 1'b0, 64'h105, 64'h0, 64'hffff_ffff_ffff_ffd2, 1'b0);
    add_entry("lh_h1", lsu_pkg::op_lh, 1'b0, 64'h102, 64'h0, 64'hffff_ffff_ffff_b4a5, 1'b0);
    add_entry("lhu_h3", lsu_pkg::op_lhu, 1'b0, 64'h106, 64'h0, 64'h0000_0000_0000_f0e1, 1'b0);
    add_entry("lw_w0", lsu_pkg::op_lw, 1'b0, 64'h100, 64'h0, 64'hffff_ffff_b4a5_9687, 1'b0);
    add_entry("lw_w1", lsu_pkg::op_lw, 1'b0, 64'h104, 64'h0, 64'hffff_ffff_f0e1_d2c3, 1'b0);
    add_entry("lwu_w1", lsu_pkg::op_lwu, 1'b0, 64'h104, 64'h0, 64'h0000_0000_f0e1_d2c3, 1'b0);
    add_entry("ld_full", lsu_pkg::op_ld, 1'b0, 64'h100, 64'h0, 64'hf0e1_d2c3_b4a5_9687, 1'b0);
    // narrow stores must leave the neighbouring lanes alone
    add_entry("sb_b1", lsu_pkg::op_lb, 1'b1, 64'h101, 64'h1111_1111_1111_115a, 64'h0, 1'b0);
    add_entry("ld_after_sb", lsu_pkg::op_ld, 1'b0, 64'h100, 64'h0, 64'hf0e1_d2c3_b4a5_5a87, 1'b0);
    add_entry("sh_h3", lsu_pkg::op_lhu, 1'b1, 64'h106, 64'h2222_2222_2222_1234, 64'h0, 1'b0);
    add_entry("ld_after_sh", lsu_pkg::op_ld, 1'b0, 64'h100, 64'h0, 64'h1234_d2c3_b4a5_5a87, 1'b0);
    add_entry("lh_pos", lsu_pkg::op_lh, 1'b0, 64'h106, 64'h0, 64'h0000_0000_0000_1234, 1'b0);
    add_entry("mis_lh", lsu_pkg::op_lh, 1'b0, 64'h103, 64'h0, 64'h0, 1'b1);
    add_entry("mis_sw", lsu_pkg::op_lw, 1'b1, 64'h102, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_entry("mis_ld", lsu_pkg::op_ld, 1'b0, 64'h104, 64'h0, 64'h0, 1'b1);
    add_entry("mis_sd", lsu_pkg::op_ld, 1'b1, 64'h101, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_entry("ld_after_mis", lsu_pkg::op_ld, 1'b0, 64'h100, 64'h0, 64'h1234_d2c3_b4a5_5a87, 1'b0);
    add_entry("oor_sd", lsu_pkg::op_ld, 1'b1, 64'h1000, 64'haaaa_aaaa_aaaa_aaaa, 64'h0, 1'b1);
    add_entry("oor_ld", lsu_pkg::op_ld, 1'b0, 64'h1000, 64'h0, 64'h0, 1'b1);
    add_entry("oor_lbu", lsu_pkg::op_lbu, 1'b0, 64'h8000_0000_0000_0007, 64'h0, 64'h0, 1'b1);
    add_entry("none_st", lsu_pkg::op_none, 1'b1, 64'h100, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b0);
    add_entry("none_ld", lsu_pkg::op_none, 1'b0, 64'h100, 64'h0, 64'h0, 1'b0);
    add_entry("ld_after_non", lsu_pkg::op_ld, 1'b0, 64'h100, 64'h0, 64'h1234_d2c3_b4a5_5a87, 1'b0);
    add_random_pairs(RANDOM_PAIRS);
  endtask

  // one request on a falling edge, then wait for the response pulse
  task automatic run_entry(input entry_t e, input int idx);
    int waited;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    cur_name      = e.name;
    cur_index     = idx;
    exp_rsp.data  = e.exp_data;
    exp_rsp.err   = e.exp_err;
    req.addr      = e.addr;
    req.wdata     = e.data;
    req.op        = e.op;
    req.write     = e.write;
    req_valid     = 1'b1;
    @(negedge clk);  // ready was high across the rising edge, so it transferred
    req_valid = 1'b0;
    waited    = 0;
    while (!rsp_valid && waited < CYCLES_PER_ENTRY) begin
      @(negedge clk);
      waited++;
    end
  endtask

  initial begin
    seed        = 32'h641d53a7;
    rst         = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    exp_rsp     = '0;
    cur_name    = '0;
    cur_index   = 0;
    table_built = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b1;
    foreach (table_q[i]) run_entry(table_q[i], i);
    repeat (3) @(negedge clk);
    $display("summary: %0d entries, %0d checks, %0d errors", table_q.size(), checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (table_built);
    #((table_q.size() * CYCLES_PER_ENTRY + RESET_CYCLES) * CLK_PERIOD);
    $display("watchdog expired, the table did not finish in the allowed time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: tb_lsu_checker.sv
// one request in flight at a time; reference memory bytes stay unknown until written
`timescale 1ns/10ps
`include "lsu_defs.svh"

module tb_lsu_checker (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_req_valid,
  input  logic              i_req_ready,
  input  lsu_pkg::lsu_req_t i_req,
  input  logic              i_rsp_valid,
  input  lsu_pkg::lsu_rsp_t i_rsp,
  input  lsu_pkg::lsu_rsp_t i_exp,  // table values for the current entry
  input  logic [95:0]       i_name,
  input  int                i_index,
  output int                o_errors,
  output int                o_checks
);

  localparam int IDX_W     = $clog2(`LSU_DMEM_WORDS);
  localparam int RSP_LIMIT = 20;

  logic [`LSU_XLEN-1:0] ref_mem [`LSU_DMEM_WORDS];
  lsu_pkg::lsu_rsp_t    model_rsp;
  logic                 waiting = 1'b0;
  int                   wait_cycles = 0;
  int                   errors = 0;
  int                   checks = 0;

  function automatic int op_bytes(input lsu_pkg::mem_op_e op);
    case (op)
      lsu_pkg::op_lb, lsu_pkg::op_lbu: return 1;
      lsu_pkg::op_lh, lsu_pkg::op_lhu: return 2;
      lsu_pkg::op_lw, lsu_pkg::op_lwu: return 4;
      lsu_pkg::op_ld:                  return 8;
      default:                         return 0;
    endcase
  endfunction

  function automatic logic [`LSU_XLEN-1:0] model_load(input lsu_pkg::mem_op_e op,
                                                      input logic [`LSU_XLEN-1:0] v);
    case (op)
      lsu_pkg::op_lb:  return {{56{v[7]}}, v[7:0]};
      lsu_pkg::op_lbu: return {56'd0, v[7:0]};
      lsu_pkg::op_lh:  return {{48{v[15]}}, v[15:0]};
      lsu_pkg::op_lhu: return {48'd0, v[15:0]};
      lsu_pkg::op_lw:  return {{32{v[31]}}, v[31:0]};
      lsu_pkg::op_lwu: return {32'd0, v[31:0]};
      default:         return v;
    endcase
  endfunction

  task automatic compare_field(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0s (entry %0d) %0s: expected %h, actual %h", i_name, i_index, what, exp, act);
    end
  endtask

  always @(posedge i_clk) begin : watch
    int                 size;
    int                 off;
    logic [`LSU_AW-4:0] widx;
    logic [IDX_W-1:0]   idx;
    if (!i_rst) begin
      waiting     = 1'b0;
      wait_cycles = 0;
    end else begin
      if (waiting) begin
        compare_field("req_ready while busy", 64'(1'b0), 64'(i_req_ready));
      end
      if (i_rsp_valid && !waiting) begin
        errors++;
        $display("a response pulse arrived with no request outstanding (entry %0d)", i_index);
      end else if (i_rsp_valid) begin
        compare_field("data vs model", model_rsp.data, i_rsp.data);
        compare_field("err vs model", 64'(model_rsp.err), 64'(i_rsp.err));
        compare_field("data vs table", i_exp.data, i_rsp.data);
        compare_field("err vs table", 64'(i_exp.err), 64'(i_rsp.err));
        waiting = 1'b0;
      end else if (waiting) begin
        wait_cycles++;
        if (wait_cycles >= RSP_LIMIT) begin
          errors++;
          $display("no response to %0s (entry %0d) within %0d cycles", i_name, i_index, RSP_LIMIT);
          waiting = 1'b0;
        end
      end
      if (i_req_valid && i_req_ready) begin
        size      = op_bytes(i_req.op);
        off       = int'(i_req.addr[2:0]);
        widx      = i_req.addr[`LSU_AW-1:3];
        idx       = i_req.addr[3 +: IDX_W];
        model_rsp = '0;
        if (size == 0) begin
          model_rsp.err = 1'b0;  // none never touches memory
        end else if (off % size != 0) begin
          model_rsp.err = 1'b1;
        end else if (widx >= (`LSU_AW-3)'(`LSU_DMEM_WORDS)) begin
          model_rsp.err = 1'b1;
        end else if (i_req.write) begin
          for (int b = 0; b < size; b++) begin
            ref_mem[idx][(off + b) * 8 +: 8] = i_req.wdata[b * 8 +: 8];
          end
        end else begin
          model_rsp.data = model_load(i_req.op, ref_mem[idx] >> (off * 8));
        end
        waiting     = 1'b1;
        wait_cycles = 0;
      end
    end
  end

  assign o_errors = errors;
  assign o_checks = checks;

endmodule
